/* vlog.f */
+incdir+.
perf_pkg.sv
edge_event_counter.sv
report_sequencer.sv
uart_tx.sv
perf_monitor_top.sv
tb_perf_monitor.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_perf_monitor
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := tb_perf_tasks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

/* tb_perf_tasks.svh */
// Bit i of lines: l1i_read, l1i_miss, l1d_read, l1d_write, l1d_miss, l2_read, l2_write, l2_miss.
task automatic drive_lines(input logic [7:0] lines);
	l1_ev.l1i_read  = lines[0];
	l1_ev.l1i_miss  = lines[1];
	l1_ev.l1d_read  = lines[2];
	l1_ev.l1d_write = lines[3];
	l1_ev.l1d_miss  = lines[4];
	l2_ev.l2_read   = lines[5];
	l2_ev.l2_write  = lines[6];
	l2_ev.l2_miss   = lines[7];
endtask

task automatic count_rises(input logic [7:0] lines);
	if (cyc / ROUND_LEN != stim_round) begin
		$display("Stimulus ran past the next snapshot at %0t", $time);
		stop_with_failure();
	end
	for (int i = 0; i < 8; i++) begin
		if (lines[i]) begin
			model_cnt[i] = model_cnt[i] + 8'd1;	// Wraps like the DUT.
		end
	end
endtask

task automatic pulse_events(input logic [7:0] lines, input int n);
	int high_cyc;
	int low_cyc;
	@(posedge clk);
	#2;
	for (int p = 0; p < n; p++) begin
		high_cyc = ($random(seed) & 3) + 1;
		low_cyc  = ($random(seed) & 3) + 1;
		drive_lines(lines);
		count_rises(lines);
		repeat (high_cyc) @(posedge clk);
		#2;
		drive_lines('0);
		repeat (low_cyc) @(posedge clk);
		#2;
	end
endtask

// One long high level, one count.
task automatic hold_events(input logic [7:0] lines, input int n_cyc);
	@(posedge clk);
	#2;
	drive_lines(lines);
	count_rises(lines);
	repeat (n_cyc) @(posedge clk);
	#2;
	drive_lines('0);
	@(posedge clk);
	#2;
endtask

task automatic wait_round_start();
	@(negedge clk);
	while (cyc % ROUND_LEN != 1) begin
		@(negedge clk);
	end
	stim_round = cyc / ROUND_LEN;
	for (int i = 0; i < 8; i++) begin
		snap_cnt[i] = model_cnt[i];
	end
endtask

task automatic recv_byte(output report_byte_t data);
	int wait_cyc;
	wait_cyc = 0;
	@(negedge clk);
	while (tx !== 1'b0) begin
		wait_cyc++;
		if (wait_cyc > 2 * SLOT_LEN) begin
			$display("No start bit on tx within %0d cycles at %0t", 2 * SLOT_LEN, $time);
			stop_with_failure();
		end
		@(negedge clk);
	end
	repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);	// Middle of start bit.
	check_bit(tx, 1'b0, "start bit");
	check_bit(tx_busy, 1'b1, "tx_busy in start bit");
	for (int b = 0; b < 8; b++) begin
		repeat (CLKS_PER_BIT) @(negedge clk);
		data[b] = tx;
		check_bit(tx_busy, 1'b1, "tx_busy in data bit");
	end
	repeat (CLKS_PER_BIT) @(negedge clk);
	check_bit(tx, 1'b1, "stop bit");
	check_bit(tx_busy, 1'b1, "tx_busy in stop bit");
endtask

task automatic recv_round();
	report_byte_t exp [6];
	report_byte_t got;
	exp[0] = snap_cnt[1];
	exp[1] = snap_cnt[0];
	exp[2] = snap_cnt[4];
	exp[3] = snap_cnt[2] + snap_cnt[3];	// Sums wrap at 8 bits.
	exp[4] = snap_cnt[7];
	exp[5] = snap_cnt[5] + snap_cnt[6];
	for (int k = 0; k < 6; k++) begin
		recv_byte(got);
		check_byte(got, exp[k], $sformatf("report byte %0d", k + 1));
	end
endtask

task automatic check_byte(input report_byte_t got, input report_byte_t exp, input string what);
	if (got !== exp) begin
		n_errors++;
		$display("CHECK FAILED at %0t: %s is %02h, expected %02h", $time, what, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		n_errors++;
		$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		stop_with_failure();
	end
endtask

/* tb_perf_monitor.sv */
`timescale 1ns/1ps

module tb_perf_monitor;
	import perf_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 5;
	localparam int ROUND_LEN  = N_SLOTS * SLOT_LEN;
	localparam int N_ROUNDS   = 9;
	localparam int TIMEOUT_NS = (N_ROUNDS + 1) * ROUND_LEN * CLK_PERIOD;	// One round spare.

	logic       clk;
	logic       rstn;
	l1_events_t l1_ev;
	l2_events_t l2_ev;
	logic       tx;
	logic       tx_busy;

	int           cyc;	// Cycles since reset release.
	int           stim_round;
	int           n_errors;
	integer       seed;
	report_byte_t model_cnt [8];	// Same line order as drive_lines.
	report_byte_t snap_cnt [8];

	perf_monitor_top perf_monitor_top_inst (
		.clk     (clk),
		.rstn    (rstn),
		.l1_ev   (l1_ev),
		.l2_ev   (l2_ev),
		.tx      (tx),
		.tx_busy (tx_busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (!rstn) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	`include "tb_perf_tasks.svh"

	task automatic stop_with_failure();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on error");
	endtask

	// Start bit of byte 1 is long past.
	task automatic skip_first_byte();
		repeat (SLOT_LEN + 2 * CLKS_PER_BIT) @(negedge clk);
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------
	task automatic test_reset_state();
		@(negedge clk);
		check_bit(tx, 1'b1, "tx after reset");
		check_bit(tx_busy, 1'b0, "tx_busy after reset");
		wait_round_start();
		recv_round();	// All zeros.
	endtask

	task automatic test_l1_lines();
		wait_round_start();
		fork
			recv_round();
			begin
				skip_first_byte();
				pulse_events(8'h02, 3);	// L1I miss.
				pulse_events(8'h01, 5);
				pulse_events(8'h10, 7);
				pulse_events(8'h04, 4);
				pulse_events(8'h08, 6);
			end
		join
	endtask

	task automatic test_l2_lines();
		wait_round_start();
		fork
			recv_round();
			begin
				skip_first_byte();
				pulse_events(8'h80, 9);	// L2 miss.
				pulse_events(8'h20, 2);
				pulse_events(8'h40, 11);
			end
		join
	endtask

	task automatic test_hold_and_simultaneous();
		wait_round_start();
		fork
			recv_round();
			begin
				skip_first_byte();
				hold_events(8'h01, 60);
				hold_events(8'he0, 40);
				pulse_events(8'hff, 3);	// Every line at once.
			end
		join
	endtask

	// Pushes every counter past 255 over four rounds.
	task automatic test_wrap_and_accumulate();
		for (int r = 0; r < 4; r++) begin
			wait_round_start();
			fork
				recv_round();
				begin
					skip_first_byte();
					pulse_events(8'hff, 70);
				end
			join
		end
	endtask

	task automatic test_last_round();
		wait_round_start();
		recv_round();
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		stop_with_failure();
	end

	initial begin
		clk        = 1'b0;
		rstn       = 1'b0;
		l1_ev      = '0;
		l2_ev      = '0;
		n_errors   = 0;
		stim_round = 0;
		seed       = 32'h69bf17d3;
		for (int i = 0; i < 8; i++) begin
			model_cnt[i] = '0;
			snap_cnt[i]  = '0;
		end
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rstn = 1'b1;
		test_reset_state();
		test_l1_lines();
		test_l2_lines();
		test_hold_and_simultaneous();
		test_wrap_and_accumulate();
		test_last_round();
		if (n_errors == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

/* perf_monitor_top.sv */
`timescale 1ns/1ps

module perf_monitor_top (
	input  logic                 clk,
	input  logic                 rstn,
	input  perf_pkg::l1_events_t l1_ev,
	input  perf_pkg::l2_events_t l2_ev,
	output logic                 tx,
	output logic                 tx_busy
);
	import perf_pkg::*;

	l1_counts_t   l1_cnt;
	l2_counts_t   l2_cnt;
	logic         send;
	report_byte_t tx_data;

	// ------------------------------------------------------------------------
	// Counter banks
	// ------------------------------------------------------------------------
	edge_event_counter #(
		.N_EVENTS (N_L1_EV)
	) l1_counter_inst (
		.clk  (clk),
		.rstn (rstn),
		.ev   (l1_ev),
		.cnt  (l1_cnt)
	);

	edge_event_counter #(
		.N_EVENTS (N_L2_EV)
	) l2_counter_inst (
		.clk  (clk),
		.rstn (rstn),
		.ev   (l2_ev),
		.cnt  (l2_cnt)
	);

	// ------------------------------------------------------------------------
	// Report path
	// ------------------------------------------------------------------------
	report_sequencer report_sequencer_inst (
		.clk     (clk),
		.rstn    (rstn),
		.l1_cnt  (l1_cnt),
		.l2_cnt  (l2_cnt),
		.busy    (tx_busy),
		.send    (send),
		.tx_data (tx_data)
	);

	uart_tx uart_tx_inst (
		.clk     (clk),
		.rstn    (rstn),
		.send    (send),
		.tx_data (tx_data),
		.tx      (tx),
		.busy    (tx_busy)	// Also seen by the sequencer check.
	);

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   send,
	input  perf_pkg::report_byte_t tx_data,
	output logic                   tx,
	output logic                   busy
);
	import perf_pkg::*;

	logic [8:0]           shift;	// Data bits then stop bit.
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic                 bit_end;

	assign bit_end = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			tx      <= 1'b1;
			busy    <= 1'b0;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (send) begin
				tx      <= 1'b0;	// Start bit.
				busy    <= 1'b1;
				bit_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (bit_end) begin
			bit_cnt <= '0;
			if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1)) begin
				busy <= 1'b0;	// Stop bit done.
			end else begin
				tx      <= shift[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// LSB first, ones fill in behind.
	always_ff @(posedge clk) begin
		if (!busy && send) begin
			shift <= {1'b1, tx_data};
		end else if (busy && bit_end) begin
			shift <= {1'b1, shift[8:1]};
		end
	end

	a_idle_high: assert property (
		@(posedge clk) disable iff (!rstn)
		!busy |-> tx
	) else $error("tx low while idle");

endmodule

/* report_sequencer.sv */
`timescale 1ns/1ps

module report_sequencer (
	input  logic                   clk,
	input  logic                   rstn,
	input  perf_pkg::l1_counts_t   l1_cnt,
	input  perf_pkg::l2_counts_t   l2_cnt,
	input  logic                   busy,
	output logic                   send,
	output perf_pkg::report_byte_t tx_data
);
	import perf_pkg::*;

	logic [SLOT_CNT_W-1:0] cyc;
	logic [SLOT_IDX_W-1:0] slot;
	logic                  slot_start;
	logic                  last_cyc;
	logic                  last_slot;

	l1_counts_t l1_snap;
	l2_counts_t l2_snap;

	// ------------------------------------------------------------------------
	// Slot timer
	// ------------------------------------------------------------------------
	assign slot_start = (cyc == '0);
	assign last_cyc   = (cyc == SLOT_CNT_W'(SLOT_LEN - 1));
	assign last_slot  = (slot == SLOT_IDX_W'(N_SLOTS - 1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cyc  <= '0;
			slot <= '0;
		end else if (last_cyc) begin
			cyc <= '0;
			if (last_slot) begin
				slot <= '0;	// Next round follows with no gap.
			end else begin
				slot <= slot + 1'b1;
			end
		end else begin
			cyc <= cyc + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Snapshot and byte select
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (slot == '0 && slot_start) begin
			l1_snap <= l1_cnt;
			l2_snap <= l2_cnt;
		end
	end

	// Report order, sums wrap at 8 bits.
	always_comb begin
		case (slot)
			SLOT_IDX_W'(1): begin
				tx_data = l1_snap.l1i_miss;
			end
			SLOT_IDX_W'(2): begin
				tx_data = l1_snap.l1i_read;
			end
			SLOT_IDX_W'(3): begin
				tx_data = l1_snap.l1d_miss;
			end
			SLOT_IDX_W'(4): begin
				tx_data = l1_snap.l1d_read + l1_snap.l1d_write;
			end
			SLOT_IDX_W'(5): begin
				tx_data = l2_snap.l2_miss;
			end
			SLOT_IDX_W'(6): begin
				tx_data = l2_snap.l2_read + l2_snap.l2_write;
			end
			default: begin
				tx_data = '0;
			end
		endcase
	end

	assign send = slot_start && (slot != '0);	// One strobe per byte slot.

	// Slot length must cover a whole frame.
	a_send_idle: assert property (
		@(posedge clk) disable iff (!rstn)
		send |-> !busy
	) else $error("send while transmitter busy");

endmodule

/* edge_event_counter.sv */
`timescale 1ns/1ps

module edge_event_counter #(
	parameter int N_EVENTS = perf_pkg::N_L1_EV
) (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic [N_EVENTS-1:0]                  ev,
	output logic [N_EVENTS*perf_pkg::CNT_W-1:0]  cnt
);
	import perf_pkg::*;

	logic [N_EVENTS-1:0] ev_prev;
	logic [N_EVENTS-1:0] rise;

	assign rise = ev & ~ev_prev;	// High now, low last cycle.

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ev_prev <= '0;
		end else begin
			ev_prev <= ev;
		end
	end

	// One wrapping counter per line.
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt <= '0;
		end else begin
			for (int i = 0; i < N_EVENTS; i++) begin
				if (rise[i]) begin
					cnt[i*CNT_W +: CNT_W] <= cnt[i*CNT_W +: CNT_W] + 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	for (genvar g = 0; g < N_EVENTS; g++) begin : g_chk
		a_cnt_on_edge: assert property (
			@(posedge clk) disable iff (!rstn)
			!$stable(cnt[g*CNT_W +: CNT_W]) |-> $past(ev[g]) && !$past(ev[g] && rstn, 2)
		) else $error("counter %0d moved without an edge", g);
	end

endmodule

/* perf_pkg.sv */
package perf_pkg;

	// ------------------------------------------------------------------------
	// Sizes and timing
	// ------------------------------------------------------------------------
	localparam int CNT_W        = 8;
	localparam int N_L1_EV      = 5;
	localparam int N_L2_EV      = 3;
	localparam int CLKS_PER_BIT = 8;
	localparam int FRAME_BITS   = 10;	// Start, 8 data, stop.
	localparam int SLOT_LEN     = 100;	// Must exceed FRAME_BITS * CLKS_PER_BIT.
	localparam int N_SLOTS      = 7;	// Snapshot slot plus six byte slots.

	localparam int SLOT_CNT_W = $clog2(SLOT_LEN);
	localparam int SLOT_IDX_W = $clog2(N_SLOTS);
	localparam int BIT_CNT_W  = $clog2(CLKS_PER_BIT);
	localparam int BIT_IDX_W  = $clog2(FRAME_BITS);

	// ------------------------------------------------------------------------
	// Event lines and counts
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic l1i_read;
		logic l1i_miss;
		logic l1d_read;
		logic l1d_write;
		logic l1d_miss;
	} l1_events_t;

	typedef struct packed {
		logic l2_read;
		logic l2_write;
		logic l2_miss;
	} l2_events_t;

	typedef struct packed {
		logic [CNT_W-1:0] l1i_read;
		logic [CNT_W-1:0] l1i_miss;
		logic [CNT_W-1:0] l1d_read;
		logic [CNT_W-1:0] l1d_write;
		logic [CNT_W-1:0] l1d_miss;
	} l1_counts_t;

	typedef struct packed {
		logic [CNT_W-1:0] l2_read;
		logic [CNT_W-1:0] l2_write;
		logic [CNT_W-1:0] l2_miss;
	} l2_counts_t;

	typedef logic [7:0] report_byte_t;

endpackage
